// ==== common/icache_pkg.sv ====
package icache_pkg;

    // address split, tag | index | offset
    localparam int TAG_W    = 23;
    localparam int INDEX_W  = 6;
    localparam int OFFSET_W = 3;

    localparam int NUM_SETS = 64;

    // one way holds a line of two words
    localparam int WORD_W = 32;
    localparam int LINE_W = 64;

    // byte address toward memory
    localparam int ADDR_W = 32;

    // controller states
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        LOOKUP  = 2'd1,
        MISS    = 2'd2,
        REPLACE = 2'd3
    } icache_state_t;

endpackage

// ==== filelist.f ====
common/icache_pkg.sv
icache/icache_req_buffer.sv
icache/icache_ctrl.sv
icache/icache_tag_store.sv
icache/icache_data_store.sv
icache/icache_data_select.sv
rtl/icache_top.sv
testbench/icache_tb_mem.sv
testbench/icache_tb.sv

// ==== icache/icache_ctrl.sv ====
`timescale 1ns/1ps

module icache_ctrl
    import icache_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic valid,
    input  logic hit,
    input  logic ret_valid,
    output logic addr_ok,
    output logic lookup_en,
    output logic rd_req,
    output logic refill_load,
    output logic refill_we,
    output logic resp_en
);

    icache_state_t state;
    icache_state_t next_state;
    logic          hit_q;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (valid) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                next_state = hit ? IDLE : MISS;
            end
            MISS: begin
                // wait for the memory as long as it takes
                if (ret_valid) begin
                    next_state = REPLACE;
                end
            end
            REPLACE: begin
                next_state = LOOKUP;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            hit_q <= 1'b0;
        end else begin
            state <= next_state;
            hit_q <= (state == LOOKUP) && hit;
        end
    end

    assign addr_ok     = (state == IDLE);
    assign lookup_en   = (state == LOOKUP);
    assign rd_req      = (state == MISS);
    assign refill_load = (state == MISS) && ret_valid;
    assign refill_we   = (state == REPLACE);

    // a lookup hit always returns to IDLE so this is the IDLE cycle after it
    assign resp_en = hit_q;

    a_req_resp_excl: assert property (@(posedge clk) disable iff (rst)
        !(rd_req && resp_en));

    // the lookup after a refill must find the line just written
    a_refill_then_lookup: assert property (@(posedge clk) disable iff (rst)
        refill_we |=> !refill_we && lookup_en && hit);

    a_ret_in_miss: assert property (@(posedge clk) disable iff (rst)
        ret_valid |-> (state == MISS))
        else $error("ret_valid seen outside MISS");

endmodule

// ==== icache/icache_data_select.sv ====
`timescale 1ns/1ps

module icache_data_select
    import icache_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                lookup_en,
    input  logic                refill_load,
    input  logic [LINE_W-1:0]   ret_data,
    input  logic [1:0]          way_hit,
    input  logic [OFFSET_W-1:0] req_offset,
    input  logic [2*LINE_W-1:0] line_rdata,
    input  logic                resp_en,
    output logic [LINE_W-1:0]   refill_line,
    output logic                data_ok,
    output logic [WORD_W-1:0]   rdata
);

    logic [1:0]        way_hit_q;
    logic [LINE_W-1:0] hit_line;

    // line from memory, written into the RAM during REPLACE
    always_ff @(posedge clk) begin
        if (refill_load) begin
            refill_line <= ret_data;
        end
    end

    // aligned with the RAM read issued in LOOKUP
    always_ff @(posedge clk) begin
        if (rst) begin
            way_hit_q <= '0;
        end else if (lookup_en) begin
            way_hit_q <= way_hit;
        end
    end

    assign hit_line = way_hit_q[1] ? line_rdata[LINE_W +: LINE_W] : line_rdata[0 +: LINE_W];

    // offset bit 2 picks the upper word
    assign rdata   = req_offset[2] ? hit_line[WORD_W +: WORD_W] : hit_line[0 +: WORD_W];
    assign data_ok = resp_en;

    // the response must come from exactly one way
    a_resp_onehot: assert property (@(posedge clk) disable iff (rst)
        resp_en |-> $onehot(way_hit_q));

endmodule

// ==== icache/icache_data_store.sv ====
`timescale 1ns/1ps

module icache_data_store
    import icache_pkg::*;
(
    input  logic                clk,
    input  logic                rd_en,
    input  logic                we,
    input  logic                way,
    input  logic [INDEX_W-1:0]  addr,
    input  logic [LINE_W-1:0]   wdata,
    output logic [2*LINE_W-1:0] rdata
);

    // way 1 in the upper half, way 0 in the lower half
    logic [2*LINE_W-1:0] mem [NUM_SETS];

    // single port, a write takes the port for its cycle
    always_ff @(posedge clk) begin
        if (we) begin
            if (way) begin
                mem[addr][LINE_W +: LINE_W] <= wdata;
            end else begin
                mem[addr][0 +: LINE_W] <= wdata;
            end
        end else if (rd_en) begin
            rdata <= mem[addr];
        end
    end

endmodule

// ==== icache/icache_req_buffer.sv ====
`timescale 1ns/1ps

module icache_req_buffer
    import icache_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                load,
    input  logic [TAG_W-1:0]    tag,
    input  logic [INDEX_W-1:0]  index,
    input  logic [OFFSET_W-1:0] offset,
    output logic [TAG_W-1:0]    req_tag,
    output logic [INDEX_W-1:0]  req_index,
    output logic [OFFSET_W-1:0] req_offset
);

    // held for the whole lookup, miss and refill sequence
    always_ff @(posedge clk) begin
        if (rst) begin
            req_tag    <= '0;
            req_index  <= '0;
            req_offset <= '0;
        end else if (load) begin
            req_tag    <= tag;
            req_index  <= index;
            req_offset <= offset;
        end
    end

endmodule

// ==== icache/icache_tag_store.sv ====
`timescale 1ns/1ps

module icache_tag_store
    import icache_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               lookup_en,
    input  logic               refill_we,
    input  logic [TAG_W-1:0]   req_tag,
    input  logic [INDEX_W-1:0] req_index,
    output logic [1:0]         way_hit,
    output logic               hit,
    output logic               victim_way
);

    logic [NUM_SETS-1:0] valid_way0;
    logic [NUM_SETS-1:0] valid_way1;

    // lru[set] names the way to evict next
    logic [NUM_SETS-1:0] lru;

    logic [TAG_W-1:0] tag_way0 [NUM_SETS];
    logic [TAG_W-1:0] tag_way1 [NUM_SETS];

    logic set_valid0;
    logic set_valid1;

    assign set_valid0 = valid_way0[req_index];
    assign set_valid1 = valid_way1[req_index];

    assign way_hit[0] = lookup_en && set_valid0 && (tag_way0[req_index] == req_tag);
    assign way_hit[1] = lookup_en && set_valid1 && (tag_way1[req_index] == req_tag);
    assign hit        = |way_hit;

    // fill an empty way before evicting anything
    always_comb begin
        if (!set_valid0) begin
            victim_way = 1'b0;
        end else if (!set_valid1) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru[req_index];
        end
    end

    always_ff @(posedge clk) begin
        if (refill_we) begin
            if (victim_way) begin
                tag_way1[req_index] <= req_tag;
            end else begin
                tag_way0[req_index] <= req_tag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_way0 <= '0;
            valid_way1 <= '0;
            lru        <= '0;
        end else begin
            if (refill_we) begin
                if (victim_way) begin
                    valid_way1[req_index] <= 1'b1;
                end else begin
                    valid_way0[req_index] <= 1'b1;
                end
            end
            // point at the way that was not hit
            if (hit) begin
                lru[req_index] <= way_hit[0];
            end
        end
    end

    // a refill never duplicates a tag already resident in the set
    a_one_way_hit: assert property (@(posedge clk) disable iff (rst)
        !(way_hit[0] && way_hit[1]));

endmodule

// ==== rtl/icache_top.sv ====
`timescale 1ns/1ps

module icache_top
    import icache_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                valid,
    input  logic [TAG_W-1:0]    tag,
    input  logic [INDEX_W-1:0]  index,
    input  logic [OFFSET_W-1:0] offset,
    output logic                addr_ok,
    output logic                data_ok,
    output logic [WORD_W-1:0]   rdata,
    output logic                rd_req,
    output logic [ADDR_W-1:0]   rd_addr,
    input  logic                ret_valid,
    input  logic [LINE_W-1:0]   ret_data
);

    logic                req_load;
    logic [TAG_W-1:0]    req_tag;
    logic [INDEX_W-1:0]  req_index;
    logic [OFFSET_W-1:0] req_offset;

    logic lookup_en;
    logic refill_load;
    logic refill_we;
    logic resp_en;

    logic [1:0] way_hit;
    logic       hit;
    logic       victim_way;

    logic [LINE_W-1:0]   refill_line;
    logic [2*LINE_W-1:0] line_rdata;

    // request accepted on this edge
    assign req_load = addr_ok & valid;

    // line-aligned refill address
    assign rd_addr = {req_tag, req_index, {OFFSET_W{1'b0}}};

    icache_req_buffer u_req_buffer (
        .clk        (clk),
        .rst        (rst),
        .load       (req_load),
        .tag        (tag),
        .index      (index),
        .offset     (offset),
        .req_tag    (req_tag),
        .req_index  (req_index),
        .req_offset (req_offset)
    );

    icache_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .valid       (valid),
        .hit         (hit),
        .ret_valid   (ret_valid),
        .addr_ok     (addr_ok),
        .lookup_en   (lookup_en),
        .rd_req      (rd_req),
        .refill_load (refill_load),
        .refill_we   (refill_we),
        .resp_en     (resp_en)
    );

    icache_tag_store u_tag_store (
        .clk        (clk),
        .rst        (rst),
        .lookup_en  (lookup_en),
        .refill_we  (refill_we),
        .req_tag    (req_tag),
        .req_index  (req_index),
        .way_hit    (way_hit),
        .hit        (hit),
        .victim_way (victim_way)
    );

    icache_data_store u_data_store (
        .clk   (clk),
        .rd_en (lookup_en),
        .we    (refill_we),
        .way   (victim_way),
        .addr  (req_index),
        .wdata (refill_line),
        .rdata (line_rdata)
    );

    icache_data_select u_data_select (
        .clk         (clk),
        .rst         (rst),
        .lookup_en   (lookup_en),
        .refill_load (refill_load),
        .ret_data    (ret_data),
        .way_hit     (way_hit),
        .req_offset  (req_offset),
        .line_rdata  (line_rdata),
        .resp_en     (resp_en),
        .refill_line (refill_line),
        .data_ok     (data_ok),
        .rdata       (rdata)
    );

endmodule

// ==== testbench/icache_tb.sv ====
`timescale 1ns/1ps

module icache_tb
    import icache_pkg::*;
();

    localparam int ACCEPT_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT  = 300;

    logic                clk;
    logic                rst;
    logic                valid;
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
    logic                addr_ok;
    logic                data_ok;
    logic [WORD_W-1:0]   rdata;
    logic                rd_req;
    logic [ADDR_W-1:0]   rd_addr;
    logic                ret_valid;
    logic [LINE_W-1:0]   ret_data;

    int cycle;
    int data_errors;
    int proto_errors;
    int accept_count;
    int resp_count;
    int rd_req_count;
    int model_miss_count;
    logic timed_out;
    logic [31:0] rng;

    // outstanding requests, front is the one in flight
    logic [ADDR_W-1:0] q_addr [$];
    logic              q_miss [$];
    int                q_cycle [$];

    // reference model of the cache contents
    logic             model_valid [NUM_SETS][2];
    logic [TAG_W-1:0] model_tag [NUM_SETS][2];
    logic             model_lru [NUM_SETS];

    icache_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .valid     (valid),
        .tag       (tag),
        .index     (index),
        .offset    (offset),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .ret_valid (ret_valid),
        .ret_data  (ret_data)
    );

    icache_tb_mem u_mem (
        .clk       (clk),
        .rst       (rst),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .ret_valid (ret_valid),
        .ret_data  (ret_data)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // expected instruction word for any byte address
    function automatic logic [WORD_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
        logic [31:0] h;
        h = {3'b000, addr[31:3]} ^ {addr[2], 31'b0};
        h = h * 32'h9e37_79b1;
        h = h ^ (h >> 16);
        return h;
    endfunction

    function automatic logic [ADDR_W-1:0] make_addr(input logic [TAG_W-1:0] t,
                                                    input logic [INDEX_W-1:0] s,
                                                    input logic [OFFSET_W-1:0] o);
        return {t, s, o};
    endfunction

    // returns 1 on a miss and updates valid, tags and lru like the cache
    function automatic logic model_access(input logic [ADDR_W-1:0] addr);
        logic [TAG_W-1:0]   t;
        logic [INDEX_W-1:0] s;
        logic               victim;
        t = addr[ADDR_W-1 -: TAG_W];
        s = addr[OFFSET_W +: INDEX_W];
        if (model_valid[s][0] && model_tag[s][0] == t) begin
            model_lru[s] = 1'b1;
            return 1'b0;
        end
        if (model_valid[s][1] && model_tag[s][1] == t) begin
            model_lru[s] = 1'b0;
            return 1'b0;
        end
        if (!model_valid[s][0]) begin
            victim = 1'b0;
        end else if (!model_valid[s][1]) begin
            victim = 1'b1;
        end else begin
            victim = model_lru[s];
        end
        model_valid[s][victim] = 1'b1;
        model_tag[s][victim]   = t;
        // the lookup after refill hits the new way
        model_lru[s] = ~victim;
        return 1'b1;
    endfunction

    // called at 1 ns after a rising edge, returns at the same point
    task automatic issue_read(input logic [ADDR_W-1:0] addr);
        int waited;
        int acc_cycle;
        logic miss;
        if (!timed_out) begin
            valid  = 1'b1;
            tag    = addr[ADDR_W-1 -: TAG_W];
            index  = addr[OFFSET_W +: INDEX_W];
            offset = addr[OFFSET_W-1:0];
            waited = 0;
            while (!addr_ok && waited < ACCEPT_TIMEOUT) begin
                @(posedge clk);
                #1;
                waited++;
            end
            if (!addr_ok) begin
                $display("timeout: cache never accepted the request for address %h", addr);
                timed_out = 1'b1;
                valid     = 1'b0;
            end else begin
                acc_cycle = cycle;
                @(posedge clk);
                #1;
                valid = 1'b0;
                miss  = model_access(addr);
                if (miss) begin
                    model_miss_count++;
                end
                q_addr.push_back(addr);
                q_miss.push_back(miss);
                q_cycle.push_back(acc_cycle);
                accept_count++;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    initial begin
        cycle = 0;
        forever begin
            @(posedge clk);
            cycle = cycle + 1;
        end
    end

    // compare every response and refill request with the queue
    initial begin
        logic rd_req_q;
        logic saw_req;
        logic [WORD_W-1:0] exp;
        rd_req_q = 1'b0;
        saw_req  = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (rd_req && !rd_req_q) begin
                    rd_req_count++;
                    if (q_addr.size() == 0) begin
                        $display("ERR @%0t: rd_req with no request outstanding", $time);
                        proto_errors++;
                    end else begin
                        saw_req = 1'b1;
                        if (!q_miss[0]) begin
                            $display("ERR @%0t: rd_req for predicted hit %h", $time, q_addr[0]);
                            proto_errors++;
                        end
                        if (rd_addr != {q_addr[0][ADDR_W-1:OFFSET_W], 3'b000}) begin
                            $display("ERR @%0t: rd_addr %h for request %h",
                                     $time, rd_addr, q_addr[0]);
                            proto_errors++;
                        end
                    end
                end
                if (data_ok) begin
                    if (q_addr.size() == 0) begin
                        $display("ERR @%0t: data_ok with no request outstanding", $time);
                        proto_errors++;
                    end else begin
                        exp = expected_word(q_addr[0]);
                        if (rdata !== exp) begin
                            $display("ERR @%0t: addr %h rdata %h expected %h",
                                     $time, q_addr[0], rdata, exp);
                            data_errors++;
                        end
                        if (q_miss[0] && !saw_req) begin
                            $display("ERR @%0t: predicted miss %h without rd_req", $time, q_addr[0]);
                            proto_errors++;
                        end
                        if (!q_miss[0] && cycle != q_cycle[0] + 2) begin
                            $display("ERR @%0t: hit %h took %0d cycles", $time, q_addr[0],
                                     cycle - q_cycle[0]);
                            proto_errors++;
                        end
                        void'(q_addr.pop_front());
                        void'(q_miss.pop_front());
                        void'(q_cycle.pop_front());
                        resp_count++;
                        saw_req = 1'b0;
                    end
                end
            end
            rd_req_q = rd_req;
        end
    end

    initial begin
        int waited;
        rst    = 1'b1;
        valid  = 1'b0;
        tag    = '0;
        index  = '0;
        offset = '0;
        data_errors      = 0;
        proto_errors     = 0;
        accept_count     = 0;
        resp_count       = 0;
        rd_req_count     = 0;
        model_miss_count = 0;
        timed_out        = 1'b0;
        rng              = 32'h5b36_be8e;
        for (int s = 0; s < NUM_SETS; s++) begin
            model_valid[s][0] = 1'b0;
            model_valid[s][1] = 1'b0;
            model_tag[s][0]   = '0;
            model_tag[s][1]   = '0;
            model_lru[s]      = 1'b0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        if (addr_ok !== 1'b1 || rd_req !== 1'b0 || data_ok !== 1'b0) begin
            $display("ERR @%0t: after reset addr_ok %b rd_req %b data_ok %b",
                     $time, addr_ok, rd_req, data_ok);
            proto_errors++;
        end

        // first access misses, then both words of the line hit
        issue_read(make_addr(23'h12_3456, 6'd3, 3'd0));
        issue_read(make_addr(23'h12_3456, 6'd3, 3'd4));
        issue_read(make_addr(23'h12_3456, 6'd3, 3'd0));

        // three tags in one set
        issue_read(make_addr(23'h1, 6'd5, 3'd0));
        issue_read(make_addr(23'h2, 6'd5, 3'd4));
        issue_read(make_addr(23'h1, 6'd5, 3'd4));
        issue_read(make_addr(23'h2, 6'd5, 3'd0));
        issue_read(make_addr(23'h3, 6'd5, 3'd0));
        issue_read(make_addr(23'h2, 6'd5, 3'd4));
        issue_read(make_addr(23'h1, 6'd5, 3'd0));

        for (int i = 0; i < 150; i++) begin
            rng = xorshift32(rng);
            issue_read(rng);
        end

        // few tags and sets, so hits and evictions mix
        for (int i = 0; i < 150; i++) begin
            rng = xorshift32(rng);
            issue_read(make_addr(23'h40 + rng[1:0], 6'd8 + rng[5:4], {rng[6], 2'b00}));
        end

        waited = 0;
        while (q_addr.size() != 0 && waited < DRAIN_TIMEOUT && !timed_out) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (q_addr.size() != 0 && !timed_out) begin
            $display("timeout: %0d requests never got data_ok", q_addr.size());
            timed_out = 1'b1;
        end

        if (resp_count != accept_count) begin
            $display("ERR @%0t: %0d data_ok for %0d accepted", $time, resp_count, accept_count);
            proto_errors++;
        end
        if (rd_req_count != model_miss_count) begin
            $display("ERR @%0t: %0d rd_req for %0d predicted misses",
                     $time, rd_req_count, model_miss_count);
            proto_errors++;
        end

        $display("errors: %0d data, %0d protocol, timeout %0b; %0d requests, %0d misses",
                 data_errors, proto_errors, timed_out, accept_count, rd_req_count);
        if (data_errors == 0 && proto_errors == 0 && !timed_out) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== testbench/icache_tb_mem.sv ====
`timescale 1ns/1ps

module icache_tb_mem
    import icache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              rd_req,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic              ret_valid,
    output logic [LINE_W-1:0] ret_data
);

    logic [31:0] rng_state;
    int          latency;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // memory contents, a hash of line address and word number
    function automatic logic [WORD_W-1:0] line_word(input logic [28:0] line, input logic w);
        logic [31:0] h;
        h = {3'b000, line} ^ {w, 31'b0};
        h = h * 32'h9e37_79b1;
        h = h ^ (h >> 16);
        return h;
    endfunction

    initial begin
        rng_state = 32'h5b36_be8e;
        ret_valid = 1'b0;
        ret_data  = '0;
        forever begin
            @(posedge clk);
            #1;
            if (!rst && rd_req) begin
                rng_state = xorshift32(rng_state);
                latency   = 1 + int'(rng_state % 6);
                // earliest reply is the cycle after rd_req rose
                repeat (latency) @(posedge clk);
                #1;
                ret_valid = 1'b1;
                ret_data  = {line_word(rd_addr[31:3], 1'b1), line_word(rd_addr[31:3], 1'b0)};
                @(posedge clk);
                #1;
                ret_valid = 1'b0;
            end
        end
    end

endmodule
